// ==== udp_hdr_pkg.sv ====
// header field types for the IPv4 addresses and UDP words that the multiplexer carries; no Ethernet or other IP fields
package udp_hdr_pkg;

    // IPv4 source or destination address
    typedef logic [31:0] ip_addr_t;

    // UDP source or destination port
    typedef logic [15:0] udp_port_t;

    // UDP length, header plus payload in bytes
    typedef logic [15:0] udp_len_t;

    // UDP checksum, carried unchanged
    typedef logic [15:0] udp_csum_t;

endpackage

// ==== udp_mux_pkg.sv ====
// frame state and default sizes for the UDP multiplexer; the defaults only apply when the top level is not overridden
package udp_mux_pkg;

    // frame control state
    typedef enum logic {
        ST_IDLE  = 1'b0,
        ST_FRAME = 1'b1
    } frame_state_t;

    // number of input ports
    localparam int DEFAULT_NUM_PORTS = 4;

    // payload width in bits, a multiple of 8
    localparam int DEFAULT_DATA_WIDTH = 64;

endpackage

// ==== udp_mux_ctrl.sv ====
// frame control; a frame starts only when idle, enabled and the output header is free, and ends on the accepted tlast beat
`timescale 1ns/1ps

module udp_mux_ctrl #(
    parameter int NUM_PORTS = udp_mux_pkg::DEFAULT_NUM_PORTS
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         enable,
    input  logic [$clog2(NUM_PORTS)-1:0] select,
    input  logic [NUM_PORTS-1:0]         in_hdr_valid,
    input  logic                         sel_hdr_valid,
    input  logic                         hdr_busy,
    input  logic                         beat_accept,
    input  logic                         beat_last,
    input  logic                         ready_early,
    output logic                         hdr_capture,
    output logic [$clog2(NUM_PORTS)-1:0] cur_port,
    output logic [NUM_PORTS-1:0]         in_hdr_ready,
    output logic [NUM_PORTS-1:0]         in_tready
);

    import udp_mux_pkg::*;

    frame_state_t                 state_q;
    frame_state_t                 state_d;
    logic [$clog2(NUM_PORTS)-1:0] port_q;
    logic [$clog2(NUM_PORTS)-1:0] port_d;
    logic [NUM_PORTS-1:0]         hdr_ready_q;
    logic [NUM_PORTS-1:0]         hdr_ready_d;
    logic [NUM_PORTS-1:0]         tready_q;
    logic [NUM_PORTS-1:0]         tready_d;
    logic                         start_frame;

    assign start_frame = (state_q == ST_IDLE) && enable && !hdr_busy && sel_hdr_valid;

    // not registered, so the header lands on the same edge as the state change
    assign hdr_capture = start_frame;

    always_comb begin
        state_d = state_q;
        port_d = port_q;
        // ready pulse drops once the source has seen it
        hdr_ready_d = hdr_ready_q & ~in_hdr_valid;
        tready_d = '0;

        if (state_q == ST_FRAME) begin
            if (beat_accept && beat_last) begin
                state_d = ST_IDLE;
            end
        end else if (start_frame) begin
            state_d = ST_FRAME;
            port_d = select;
            hdr_ready_d[select] = 1'b1;
        end

        // payload ready follows the skid's early ready, one cycle later
        if (state_d == ST_FRAME) begin
            tready_d[port_d] = ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            port_q <= '0;
            hdr_ready_q <= '0;
            tready_q <= '0;
        end else begin
            state_q <= state_d;
            port_q <= port_d;
            hdr_ready_q <= hdr_ready_d;
            tready_q <= tready_d;
        end
    end

    assign cur_port = port_q;
    assign in_hdr_ready = hdr_ready_q;
    assign in_tready = tready_q;

    a_hdr_ready_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(in_hdr_ready)
    );

    a_tready_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(in_tready)
    );

    // no new header capture while the open frame still waits for its tlast beat
    a_no_capture_in_frame: assert property (
        @(posedge clk) disable iff (rst)
        (state_q == ST_FRAME) && !(beat_accept && beat_last) |=> !hdr_capture
    );

endmodule

// ==== udp_hdr_capture.sv ====
// output header register; loads the port on select at hdr_capture and holds until out_hdr_ready
`timescale 1ns/1ps

module udp_hdr_capture #(
    parameter int NUM_PORTS = udp_mux_pkg::DEFAULT_NUM_PORTS
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [$clog2(NUM_PORTS)-1:0]           select,
    input  logic                                   hdr_capture,
    input  logic [NUM_PORTS-1:0]                   in_hdr_valid,
    input  udp_hdr_pkg::ip_addr_t  [NUM_PORTS-1:0] in_ip_source_ip,
    input  udp_hdr_pkg::ip_addr_t  [NUM_PORTS-1:0] in_ip_dest_ip,
    input  udp_hdr_pkg::udp_port_t [NUM_PORTS-1:0] in_udp_source_port,
    input  udp_hdr_pkg::udp_port_t [NUM_PORTS-1:0] in_udp_dest_port,
    input  udp_hdr_pkg::udp_len_t  [NUM_PORTS-1:0] in_udp_length,
    input  udp_hdr_pkg::udp_csum_t [NUM_PORTS-1:0] in_udp_checksum,
    output logic                                   sel_hdr_valid,
    output logic                                   out_hdr_valid,
    input  logic                                   out_hdr_ready,
    output udp_hdr_pkg::ip_addr_t                  out_ip_source_ip,
    output udp_hdr_pkg::ip_addr_t                  out_ip_dest_ip,
    output udp_hdr_pkg::udp_port_t                 out_udp_source_port,
    output udp_hdr_pkg::udp_port_t                 out_udp_dest_port,
    output udp_hdr_pkg::udp_len_t                  out_udp_length,
    output udp_hdr_pkg::udp_csum_t                 out_udp_checksum
);

    import udp_hdr_pkg::*;

    ip_addr_t  sel_source_ip;
    ip_addr_t  sel_dest_ip;
    udp_port_t sel_source_port;
    udp_port_t sel_dest_port;
    udp_len_t  sel_length;
    udp_csum_t sel_checksum;

    // header of the port currently on select
    assign sel_hdr_valid = in_hdr_valid[select];
    assign sel_source_ip = in_ip_source_ip[select];
    assign sel_dest_ip = in_ip_dest_ip[select];
    assign sel_source_port = in_udp_source_port[select];
    assign sel_dest_port = in_udp_dest_port[select];
    assign sel_length = in_udp_length[select];
    assign sel_checksum = in_udp_checksum[select];

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hdr_valid <= 1'b0;
        end else if (hdr_capture) begin
            out_hdr_valid <= 1'b1;
        end else if (out_hdr_ready) begin
            out_hdr_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_capture) begin
            out_ip_source_ip <= sel_source_ip;
            out_ip_dest_ip <= sel_dest_ip;
            out_udp_source_port <= sel_source_port;
            out_udp_dest_port <= sel_dest_port;
            out_udp_length <= sel_length;
            out_udp_checksum <= sel_checksum;
        end
    end

    // the control must not start a frame while the header is still waiting
    a_hdr_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_hdr_valid && !out_hdr_ready |=>
            $stable(out_ip_source_ip) && $stable(out_ip_dest_ip) &&
            $stable(out_udp_source_port) && $stable(out_udp_dest_port) &&
            $stable(out_udp_length) && $stable(out_udp_checksum)
    );

endmodule

// ==== udp_payload_select.sv ====
// payload mux for the latched port; the accepted beat relies on in_tready being high only on that port during a frame
`timescale 1ns/1ps

module udp_payload_select #(
    parameter int NUM_PORTS  = udp_mux_pkg::DEFAULT_NUM_PORTS,
    parameter int DATA_WIDTH = udp_mux_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic [$clog2(NUM_PORTS)-1:0]           cur_port,
    input  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]   in_tdata,
    input  logic [NUM_PORTS-1:0][DATA_WIDTH/8-1:0] in_tkeep,
    input  logic [NUM_PORTS-1:0]                   in_tvalid,
    input  logic [NUM_PORTS-1:0]                   in_tready,
    input  logic [NUM_PORTS-1:0]                   in_tlast,
    input  logic [NUM_PORTS-1:0]                   in_tuser,
    output logic                                   skid_valid,
    output logic [DATA_WIDTH-1:0]                  skid_data,
    output logic [DATA_WIDTH/8-1:0]                skid_keep,
    output logic                                   skid_last,
    output logic                                   skid_user,
    output logic                                   beat_accept,
    output logic                                   beat_last
);

    logic accept;
    logic last;

    // a beat moves when the latched port offers it and its registered ready is up
    assign accept = in_tvalid[cur_port] && in_tready[cur_port];
    assign last = in_tlast[cur_port];

    assign skid_valid = accept;
    assign skid_data = in_tdata[cur_port];
    assign skid_keep = in_tkeep[cur_port];
    assign skid_last = last;
    assign skid_user = in_tuser[cur_port];

    // frame end detection in the control
    assign beat_accept = accept;
    assign beat_last = last;

endmodule

// ==== udp_payload_skid.sv ====
// two-entry output stage; the source must honour ready_early one cycle late, so at most one beat lands in temp
`timescale 1ns/1ps

module udp_payload_skid #(
    parameter int DATA_WIDTH = udp_mux_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    skid_valid,
    input  logic [DATA_WIDTH-1:0]   skid_data,
    input  logic [DATA_WIDTH/8-1:0] skid_keep,
    input  logic                    skid_last,
    input  logic                    skid_user,
    output logic                    ready_early,
    output logic [DATA_WIDTH-1:0]   out_tdata,
    output logic [DATA_WIDTH/8-1:0] out_tkeep,
    output logic                    out_tvalid,
    output logic                    out_tlast,
    output logic                    out_tuser,
    input  logic                    out_tready
);

    logic                    out_valid_q;
    logic [DATA_WIDTH-1:0]   temp_data_q;
    logic [DATA_WIDTH/8-1:0] temp_keep_q;
    logic                    temp_valid_q;
    logic                    temp_last_q;
    logic                    temp_user_q;
    logic                    ready_q;
    logic                    to_output;

    // room next cycle: output draining, both entries empty, or temp empty with nothing arriving
    assign ready_early = out_tready || (!temp_valid_q && !out_valid_q) ||
                         (!temp_valid_q && !skid_valid);

    assign to_output = out_tready || !out_valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= 1'b0;
            out_valid_q <= 1'b0;
            temp_valid_q <= 1'b0;
        end else begin
            ready_q <= ready_early;
            if (ready_q) begin
                // temp is always empty here
                if (to_output) begin
                    out_valid_q <= skid_valid;
                end else begin
                    temp_valid_q <= skid_valid;
                end
            end else if (out_tready) begin
                out_valid_q <= temp_valid_q;
                temp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ready_q) begin
            if (to_output) begin
                out_tdata <= skid_data;
                out_tkeep <= skid_keep;
                out_tlast <= skid_last;
                out_tuser <= skid_user;
            end else begin
                temp_data_q <= skid_data;
                temp_keep_q <= skid_keep;
                temp_last_q <= skid_last;
                temp_user_q <= skid_user;
            end
        end else if (out_tready) begin
            out_tdata <= temp_data_q;
            out_tkeep <= temp_keep_q;
            out_tlast <= temp_last_q;
            out_tuser <= temp_user_q;
        end
    end

    assign out_tvalid = out_valid_q;

    // the registered ready upstream must stop beats before temp overflows
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst) skid_valid |-> !temp_valid_q
    );

endmodule

// ==== udp_mux_top.sv ====
// UDP frame multiplexer; select is sampled only at frame start, NUM_PORTS >= 2, DATA_WIDTH a multiple of 8
`timescale 1ns/1ps

module udp_mux_top #(
    parameter int NUM_PORTS  = udp_mux_pkg::DEFAULT_NUM_PORTS,
    parameter int DATA_WIDTH = udp_mux_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        enable,
    input  logic [$clog2(NUM_PORTS)-1:0]                select,

    input  logic [NUM_PORTS-1:0]                        in_hdr_valid,
    output logic [NUM_PORTS-1:0]                        in_hdr_ready,
    input  udp_hdr_pkg::ip_addr_t  [NUM_PORTS-1:0]      in_ip_source_ip,
    input  udp_hdr_pkg::ip_addr_t  [NUM_PORTS-1:0]      in_ip_dest_ip,
    input  udp_hdr_pkg::udp_port_t [NUM_PORTS-1:0]      in_udp_source_port,
    input  udp_hdr_pkg::udp_port_t [NUM_PORTS-1:0]      in_udp_dest_port,
    input  udp_hdr_pkg::udp_len_t  [NUM_PORTS-1:0]      in_udp_length,
    input  udp_hdr_pkg::udp_csum_t [NUM_PORTS-1:0]      in_udp_checksum,
    input  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]        in_tdata,
    input  logic [NUM_PORTS-1:0][DATA_WIDTH/8-1:0]      in_tkeep,
    input  logic [NUM_PORTS-1:0]                        in_tvalid,
    output logic [NUM_PORTS-1:0]                        in_tready,
    input  logic [NUM_PORTS-1:0]                        in_tlast,
    input  logic [NUM_PORTS-1:0]                        in_tuser,

    output logic                                        out_hdr_valid,
    input  logic                                        out_hdr_ready,
    output udp_hdr_pkg::ip_addr_t                       out_ip_source_ip,
    output udp_hdr_pkg::ip_addr_t                       out_ip_dest_ip,
    output udp_hdr_pkg::udp_port_t                      out_udp_source_port,
    output udp_hdr_pkg::udp_port_t                      out_udp_dest_port,
    output udp_hdr_pkg::udp_len_t                       out_udp_length,
    output udp_hdr_pkg::udp_csum_t                      out_udp_checksum,
    output logic [DATA_WIDTH-1:0]                       out_tdata,
    output logic [DATA_WIDTH/8-1:0]                     out_tkeep,
    output logic                                        out_tvalid,
    input  logic                                        out_tready,
    output logic                                        out_tlast,
    output logic                                        out_tuser
);

    logic                         sel_hdr_valid;
    logic                         hdr_capture;
    logic [$clog2(NUM_PORTS)-1:0] cur_port;
    logic                         beat_accept;
    logic                         beat_last;
    logic                         ready_early;
    logic                         skid_valid;
    logic [DATA_WIDTH-1:0]        skid_data;
    logic [DATA_WIDTH/8-1:0]      skid_keep;
    logic                         skid_last;
    logic                         skid_user;

    udp_mux_ctrl #(
        .NUM_PORTS(NUM_PORTS)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .select       (select),
        .in_hdr_valid (in_hdr_valid),
        .sel_hdr_valid(sel_hdr_valid),
        .hdr_busy     (out_hdr_valid),
        .beat_accept  (beat_accept),
        .beat_last    (beat_last),
        .ready_early  (ready_early),
        .hdr_capture  (hdr_capture),
        .cur_port     (cur_port),
        .in_hdr_ready (in_hdr_ready),
        .in_tready    (in_tready)
    );

    udp_hdr_capture #(
        .NUM_PORTS(NUM_PORTS)
    ) u_hdr_capture (
        .clk                (clk),
        .rst                (rst),
        .select             (select),
        .hdr_capture        (hdr_capture),
        .in_hdr_valid       (in_hdr_valid),
        .in_ip_source_ip    (in_ip_source_ip),
        .in_ip_dest_ip      (in_ip_dest_ip),
        .in_udp_source_port (in_udp_source_port),
        .in_udp_dest_port   (in_udp_dest_port),
        .in_udp_length      (in_udp_length),
        .in_udp_checksum    (in_udp_checksum),
        .sel_hdr_valid      (sel_hdr_valid),
        .out_hdr_valid      (out_hdr_valid),
        .out_hdr_ready      (out_hdr_ready),
        .out_ip_source_ip   (out_ip_source_ip),
        .out_ip_dest_ip     (out_ip_dest_ip),
        .out_udp_source_port(out_udp_source_port),
        .out_udp_dest_port  (out_udp_dest_port),
        .out_udp_length     (out_udp_length),
        .out_udp_checksum   (out_udp_checksum)
    );

    udp_payload_select #(
        .NUM_PORTS (NUM_PORTS),
        .DATA_WIDTH(DATA_WIDTH)
    ) u_payload_select (
        .cur_port   (cur_port),
        .in_tdata   (in_tdata),
        .in_tkeep   (in_tkeep),
        .in_tvalid  (in_tvalid),
        .in_tready  (in_tready),
        .in_tlast   (in_tlast),
        .in_tuser   (in_tuser),
        .skid_valid (skid_valid),
        .skid_data  (skid_data),
        .skid_keep  (skid_keep),
        .skid_last  (skid_last),
        .skid_user  (skid_user),
        .beat_accept(beat_accept),
        .beat_last  (beat_last)
    );

    udp_payload_skid #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_payload_skid (
        .clk        (clk),
        .rst        (rst),
        .skid_valid (skid_valid),
        .skid_data  (skid_data),
        .skid_keep  (skid_keep),
        .skid_last  (skid_last),
        .skid_user  (skid_user),
        .ready_early(ready_early),
        .out_tdata  (out_tdata),
        .out_tkeep  (out_tkeep),
        .out_tvalid (out_tvalid),
        .out_tlast  (out_tlast),
        .out_tuser  (out_tuser),
        .out_tready (out_tready)
    );

endmodule

// ==== tb_udp_mux.sv ====
// testbench for udp_mux_top with default parameters; all sources offer headers and beats at all times
`timescale 1ns/1ps

module tb_udp_mux;

    import udp_hdr_pkg::*;
    import udp_mux_pkg::*;

    localparam int NUM_PORTS  = DEFAULT_NUM_PORTS;
    localparam int DATA_WIDTH = DEFAULT_DATA_WIDTH;
    localparam int KEEP_W     = DATA_WIDTH / 8;
    localparam int SEL_W      = $clog2(NUM_PORTS);
    localparam int TIMEOUT    = 200;
    localparam int NUM_ROWS   = 7;

    logic clk = 1'b0;
    logic rst;
    logic enable;
    logic [SEL_W-1:0] select;
    logic [NUM_PORTS-1:0] in_hdr_valid;
    logic [NUM_PORTS-1:0] in_hdr_ready;
    ip_addr_t  [NUM_PORTS-1:0] in_ip_source_ip;
    ip_addr_t  [NUM_PORTS-1:0] in_ip_dest_ip;
    udp_port_t [NUM_PORTS-1:0] in_udp_source_port;
    udp_port_t [NUM_PORTS-1:0] in_udp_dest_port;
    udp_len_t  [NUM_PORTS-1:0] in_udp_length;
    udp_csum_t [NUM_PORTS-1:0] in_udp_checksum;
    logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] in_tdata;
    logic [NUM_PORTS-1:0][KEEP_W-1:0] in_tkeep;
    logic [NUM_PORTS-1:0] in_tvalid;
    logic [NUM_PORTS-1:0] in_tready;
    logic [NUM_PORTS-1:0] in_tlast;
    logic [NUM_PORTS-1:0] in_tuser;
    logic out_hdr_valid;
    logic out_hdr_ready;
    ip_addr_t  out_ip_source_ip;
    ip_addr_t  out_ip_dest_ip;
    udp_port_t out_udp_source_port;
    udp_port_t out_udp_dest_port;
    udp_len_t  out_udp_length;
    udp_csum_t out_udp_checksum;
    logic [DATA_WIDTH-1:0] out_tdata;
    logic [KEEP_W-1:0] out_tkeep;
    logic out_tvalid;
    logic out_tready;
    logic out_tlast;
    logic out_tuser;

    // source model state per port
    int hdr_frame [NUM_PORTS];
    int pay_frame [NUM_PORTS];
    int pay_beat [NUM_PORTS];
    int nbeats [NUM_PORTS];
    logic [NUM_PORTS-1:0] hdr_taken;
    logic [NUM_PORTS-1:0] beat_taken;

    integer seed;
    int mismatch_count;
    int other_errors;
    bit aborted;

    // port, enable low cycles, beats, header hold cycles, back-pressure, select change (-1 none)
    int row_port [NUM_ROWS] = '{0, 2, 1, 3, 3, 0, 2};
    int row_en_low [NUM_ROWS] = '{2, 0, 5, 1, 0, 3, 0};
    int row_beats [NUM_ROWS] = '{1, 3, 5, 2, 4, 5, 1};
    int row_hold [NUM_ROWS] = '{0, 4, 0, 7, 2, 1, 3};
    int row_bp [NUM_ROWS] = '{0, 1, 1, 0, 1, 0, 1};
    int row_new_sel [NUM_ROWS] = '{-1, 1, 3, -1, 0, 2, -1};

    udp_mux_top DUT (.*);

    always #2 clk = ~clk;

    // source ip, dest ip, source port, dest port, length, checksum
    function automatic logic [127:0] hdr_word(input int p, input int f);
        logic [15:0] tag;
        tag = {4'(p), 12'(f)};
        return {16'hc0a8, tag, 16'h0a00, ~tag, 16'h1000 ^ tag, tag + 16'h0035,
                16'h0008 + 16'(f), tag ^ 16'hbeef};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] beat_data(input int p, input int f, input int b);
        return DATA_WIDTH'({8'ha5, 8'(p), 16'(f), 16'hc3c3, 16'(b)});
    endfunction

    function automatic logic [KEEP_W-1:0] beat_keep(input int p, input int f, input logic last);
        return last ? ({KEEP_W{1'b1}} >> ((p + f) % KEEP_W)) : {KEEP_W{1'b1}};
    endfunction

    function automatic logic beat_user(input int p, input int f, input int b);
        return ((p + f + b) % 3) == 0;
    endfunction

    task automatic drive_sources();
        for (int p = 0; p < NUM_PORTS; p++) begin
            {in_ip_source_ip[p], in_ip_dest_ip[p], in_udp_source_port[p], in_udp_dest_port[p],
             in_udp_length[p], in_udp_checksum[p]} = hdr_word(p, hdr_frame[p]);
            in_tdata[p] = beat_data(p, pay_frame[p], pay_beat[p]);
            in_tlast[p] = (pay_beat[p] == nbeats[p] - 1);
            in_tkeep[p] = beat_keep(p, pay_frame[p], in_tlast[p]);
            in_tuser[p] = beat_user(p, pay_frame[p], pay_beat[p]);
        end
        in_hdr_valid = '1;
        in_tvalid = '1;
    endtask

    always @(negedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (hdr_taken[p]) begin
                hdr_frame[p] = hdr_frame[p] + 1;
            end
            if (beat_taken[p] && in_tlast[p]) begin
                pay_frame[p] = pay_frame[p] + 1;
                pay_beat[p] = 0;
            end else if (beat_taken[p]) begin
                pay_beat[p] = pay_beat[p] + 1;
            end
        end
        drive_sources();
        // these transfers happen at the coming rising edge
        hdr_taken = in_hdr_valid & in_hdr_ready;
        beat_taken = in_tvalid & in_tready;
    end

    function automatic void report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        $display("MISMATCH %s: got %0h, expected %0h", name, got, exp);
        mismatch_count++;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report_mismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic check_ready(input string name, input logic [NUM_PORTS-1:0] got,
                               input logic [NUM_PORTS-1:0] exp);
        if (got !== exp) report_mismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic check_hdr(input ip_addr_t sip, input ip_addr_t dip, input udp_port_t sp,
                             input udp_port_t dp, input udp_len_t len, input udp_csum_t cs);
        if (out_ip_source_ip !== sip) report_mismatch("out_ip_source_ip", out_ip_source_ip, sip);
        if (out_ip_dest_ip !== dip) report_mismatch("out_ip_dest_ip", out_ip_dest_ip, dip);
        if (out_udp_source_port !== sp) report_mismatch("out_udp_source_port", out_udp_source_port, sp);
        if (out_udp_dest_port !== dp) report_mismatch("out_udp_dest_port", out_udp_dest_port, dp);
        if (out_udp_length !== len) report_mismatch("out_udp_length", out_udp_length, len);
        if (out_udp_checksum !== cs) report_mismatch("out_udp_checksum", out_udp_checksum, cs);
    endtask

    task automatic check_beat(input logic [DATA_WIDTH-1:0] data, input logic [KEEP_W-1:0] keep,
                              input logic last, input logic user);
        if (out_tdata !== data) report_mismatch("out_tdata", out_tdata, data);
        if (out_tkeep !== keep) report_mismatch("out_tkeep", 64'(out_tkeep), 64'(keep));
        check_bit("out_tlast", out_tlast, last);
        check_bit("out_tuser", out_tuser, user);
    endtask

    // holds the output header for a while, then takes it and closes the enable gate
    task automatic take_header(input int hold, input int new_sel, input logic [127:0] h);
        if (new_sel >= 0) select = SEL_W'(new_sel);
        repeat (hold) begin
            @(negedge clk);
            check_ready("in_hdr_ready", in_hdr_ready, '0);
            check_bit("out_hdr_valid", out_hdr_valid, 1'b1);
            check_hdr(h[127:96], h[95:64], h[63:48], h[47:32], h[31:16], h[15:0]);
        end
        out_hdr_ready = 1'b1;
        enable = 1'b0;
        @(negedge clk);
        out_hdr_ready = 1'b0;
        check_bit("out_hdr_valid", out_hdr_valid, 1'b0);
    endtask

    task automatic collect_payload(input int port, input int frame, input int beats, input int bp);
        int n;
        int wait_cnt;
        n = 0;
        wait_cnt = 0;
        while (n < beats && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
            out_tready = (bp != 0) ? 1'($random(seed)) : 1'b1;
            if (out_tvalid && out_tready) begin
                check_beat(beat_data(port, frame, n), beat_keep(port, frame, n == beats - 1),
                           n == beats - 1, beat_user(port, frame, n));
                n++;
            end
        end
        if (n < beats) begin
            $display("timeout: port %0d delivered only %0d of %0d beats", port, n, beats);
            other_errors++;
            aborted = 1'b1;
        end
    endtask

    initial begin
        logic [127:0] exp_hdr;
        int exp_frame;
        int port;
        int wait_cnt;
        seed = 32'h64b7_c221;
        mismatch_count = 0;
        other_errors = 0;
        aborted = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            hdr_frame[p] = 0;
            pay_frame[p] = 0;
            pay_beat[p] = 0;
            nbeats[p] = 2;
        end
        hdr_taken = '0;
        beat_taken = '0;
        rst = 1'b1;
        enable = 1'b0;
        select = '0;
        out_hdr_ready = 1'b0;
        out_tready = 1'b0;
        drive_sources();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        check_ready("in_hdr_ready", in_hdr_ready, '0);
        check_ready("in_tready", in_tready, '0);
        check_bit("out_hdr_valid", out_hdr_valid, 1'b0);
        check_bit("out_tvalid", out_tvalid, 1'b0);
        if (DUT.u_ctrl.state_q != ST_IDLE) begin
            $display("frame state is %s after reset instead of idle", DUT.u_ctrl.state_q.name());
            other_errors++;
        end

        for (int r = 0; r < NUM_ROWS && !aborted; r++) begin
            port = row_port[r];
            @(negedge clk);
            // anything still on the output here came after the last tlast
            check_bit("out_tvalid", out_tvalid, 1'b0);
            select = SEL_W'(port);
            nbeats[port] = row_beats[r];
            exp_frame = hdr_frame[port];
            repeat (row_en_low[r]) begin
                @(negedge clk);
                check_ready("in_hdr_ready", in_hdr_ready, '0);
                check_bit("out_hdr_valid", out_hdr_valid, 1'b0);
            end
            enable = 1'b1;
            @(negedge clk);
            wait_cnt = 0;
            while (in_hdr_ready == '0 && wait_cnt < TIMEOUT) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (in_hdr_ready == '0) begin
                $display("timeout: no header ready on port %0d after enable rose", port);
                other_errors++;
                aborted = 1'b1;
            end else begin
                check_ready("in_hdr_ready", in_hdr_ready, NUM_PORTS'(1 << port));
                check_bit("out_hdr_valid", out_hdr_valid, 1'b1);
                exp_hdr = hdr_word(port, exp_frame);
                check_hdr(exp_hdr[127:96], exp_hdr[95:64], exp_hdr[63:48], exp_hdr[47:32],
                          exp_hdr[31:16], exp_hdr[15:0]);
                fork
                    take_header(row_hold[r], row_new_sel[r], exp_hdr);
                    collect_payload(port, exp_frame, row_beats[r], row_bp[r]);
                join
            end
        end
        @(negedge clk);
        check_bit("out_tvalid", out_tvalid, 1'b0);

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
udp_hdr_pkg.sv
udp_mux_pkg.sv
udp_mux_ctrl.sv
udp_hdr_capture.sv
udp_payload_select.sv
udp_payload_skid.sv
udp_mux_top.sv
tb_udp_mux.sv

// ==== Bender.yml ====
package:
  name: udp_mux

sources:
  - udp_hdr_pkg.sv
  - udp_mux_pkg.sv
  - udp_mux_ctrl.sv
  - udp_hdr_capture.sv
  - udp_payload_select.sv
  - udp_payload_skid.sv
  - udp_mux_top.sv
  - target: test
    files:
      - tb_udp_mux.sv
